// File: hw/cache_pkg.sv
package cache_pkg;

////////////////////////////////////////
// Widths
////////////////////////////////////////
localparam int ADDR_W       = 16;        // Word address
localparam int DATA_W       = 32;
localparam int BE_W         = DATA_W / 8;
localparam int MAX_OFFSET_W = 4;         // Blocks of up to 16 words

// Miss handling state of the shared controller
typedef enum logic [2:0] {
    NORMAL,
    IC_MISS,
    DC_MISS,
    DOUBLE_MISS,     // I-side served first
    DC_WRITEBACK     // Dirty victim goes out before the D fill
} cache_status_e;

typedef struct packed {
    logic              rd;
    logic              wr;
    logic [BE_W-1:0]   byte_en;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
} cpu_req_t;

// Memory port command, qualified by mem_req
typedef struct packed {
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
} mem_cmd_t;

// Per-cache controls from the controller
typedef struct packed {
    logic                    enable;
    logic                    cmp;         // Compare tags, else work on the victim way
    logic                    write;
    logic [BE_W-1:0]         byte_en;
    logic [MAX_OFFSET_W-1:0] word_sel;
    logic                    fill_word_en;
} cache_ctl_t;

endpackage

// File: hw/cache_2ways.sv
`timescale 1ns/1ns

module cache_2ways import cache_pkg::*; #(
    parameter int INDEX_WIDTH  = 3,
    parameter int OFFSET_WIDTH = 2,
    localparam int TAG_W       = ADDR_W - INDEX_WIDTH - OFFSET_WIDTH
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    enable,
    input  logic                    cmp,
    input  logic                    write,
    input  logic [BE_W-1:0]         byte_en,
    input  logic                    fill_word_en,
    input  logic [TAG_W-1:0]        tag,
    input  logic [INDEX_WIDTH-1:0]  index,
    input  logic [OFFSET_WIDTH-1:0] word_sel,
    input  logic [DATA_W-1:0]       wdata,
    input  logic [DATA_W-1:0]       fill_word,
    output logic                    hit,
    output logic                    valid,
    output logic                    dirty,
    output logic [TAG_W-1:0]        victim_tag,
    output logic [DATA_W-1:0]       rdata
);

localparam int SETS       = 1 << INDEX_WIDTH;
localparam int BLOCK_SIZE = 1 << OFFSET_WIDTH;

////////////////////////////////////////
// Storage
////////////////////////////////////////
logic [TAG_W-1:0]  tag_mem  [2][SETS];
logic [DATA_W-1:0] data_mem [2][SETS][BLOCK_SIZE];
logic [SETS-1:0]   valid_q  [2];
logic [SETS-1:0]   dirty_q  [2];
logic [SETS-1:0]   lru_q;              // Way to replace next

logic [1:0] match;
logic       hit_way;
logic       victim;
logic       sel_way;
logic       last_word;
logic       fill_now;

// Tag compare in both ways of the set
always_comb begin
    for (int w = 0; w < 2; w++) begin
        match[w] = valid_q[w][index] && (tag_mem[w][index] == tag);
    end
end

assign hit_way   = match[1];
assign victim    = lru_q[index];
assign hit       = enable && cmp && (|match);
assign last_word = &word_sel;
assign fill_now  = enable && !cmp && fill_word_en;

// Hit way in compare mode, victim way otherwise
assign sel_way = (cmp && (|match)) ? hit_way : victim;

assign rdata      = data_mem[sel_way][index][word_sel];
assign valid      = valid_q[sel_way][index];
assign dirty      = dirty_q[victim][index];   // Drives the writeback decision
assign victim_tag = tag_mem[victim][index];

////////////////////////////////////////
// Valid, dirty and LRU bits
////////////////////////////////////////
always_ff @(posedge clk) begin
    if (rst) begin
        for (int w = 0; w < 2; w++) begin
            valid_q[w] <= '0;
            dirty_q[w] <= '0;
        end
        lru_q <= '0;
    end else if (hit) begin
        lru_q[index] <= ~hit_way;      // Other way is now the older one
        if (write) begin
            dirty_q[hit_way][index] <= 1'b1;
        end
    end else if (fill_now) begin
        if (last_word) begin
            valid_q[victim][index] <= 1'b1;
            dirty_q[victim][index] <= 1'b0;
            lru_q[index]           <= ~victim;
        end else if (word_sel == '0) begin
            // Line is unusable until its last word lands
            valid_q[victim][index] <= 1'b0;
        end
    end
end

////////////////////////////////////////
// Data and tag arrays
////////////////////////////////////////
always_ff @(posedge clk) begin
    if (hit && write) begin
        for (int b = 0; b < BE_W; b++) begin
            if (byte_en[b]) begin
                data_mem[hit_way][index][word_sel][b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
    end
    if (fill_now) begin
        data_mem[victim][index][word_sel] <= fill_word;
        if (last_word) begin
            tag_mem[victim][index] <= tag;
        end
    end
end

endmodule

// File: hw/cache_ctrl.sv
`timescale 1ns/1ns

module cache_ctrl import cache_pkg::*; #(
    parameter int INDEX_WIDTH  = 3,
    parameter int OFFSET_WIDTH = 2,
    localparam int TAG_W       = ADDR_W - INDEX_WIDTH - OFFSET_WIDTH
) (
    input  logic              clk,
    input  logic              rst,
    input  cpu_req_t          ic_req,
    input  cpu_req_t          dc_req,
    input  logic              ic_hit,
    input  logic              ic_valid,
    input  logic              dc_hit,
    input  logic              dc_dirty,
    input  logic              dc_valid,
    input  logic [TAG_W-1:0]  dc_victim_tag,
    input  logic [DATA_W-1:0] dc_victim_word,
    input  logic              mem_ack,
    input  logic [DATA_W-1:0] mem_rdata,
    output cache_ctl_t        ic_ctl,
    output cache_ctl_t        dc_ctl,
    output logic [DATA_W-1:0] fill_word,
    output logic              stall,
    output logic              mem_req,
    output mem_cmd_t          mem_cmd
);

cache_status_e status;
cache_status_e miss_next;                 // Outcome of this cycle's lookups

logic [OFFSET_WIDTH-1:0] counter;         // Word within the block
logic [INDEX_WIDTH-1:0]  dc_index;
logic                    phase;           // Ack seen, waiting for it to fall
logic                    write_after_load;
logic                    ic_miss;
logic                    dc_miss;
logic                    dc_wb_needed;
logic                    fill_strobe;
logic                    xfer_done;
logic                    last_word;

assign dc_index     = dc_req.addr[OFFSET_WIDTH +: INDEX_WIDTH];
assign ic_miss      = ic_req.rd && !(ic_hit && ic_valid);
assign dc_miss      = (dc_req.rd || dc_req.wr) && !(dc_hit && dc_valid);
assign dc_wb_needed = dc_valid && dc_dirty;   // Victim holds modified data
assign fill_strobe  = mem_req && mem_ack && !mem_cmd.write;
assign xfer_done    = phase && !mem_ack;
assign last_word    = &counter;
assign fill_word    = mem_rdata;

always_comb begin
    if (ic_miss && dc_miss) begin
        miss_next = DOUBLE_MISS;
    end else if (ic_miss) begin
        miss_next = IC_MISS;
    end else if (dc_miss) begin
        miss_next = dc_wb_needed ? DC_WRITEBACK : DC_MISS;
    end else begin
        miss_next = NORMAL;
    end
end

// Stall covers the miss being detected now as well as the one being served
assign stall = (status != NORMAL) || (miss_next != NORMAL) || write_after_load;

////////////////////////////////////////
// Cache controls
////////////////////////////////////////
always_comb begin
    ic_ctl = '0;
    dc_ctl = '0;
    case (status)
        NORMAL: begin
            ic_ctl.enable   = ic_req.rd;
            ic_ctl.cmp      = 1'b1;
            ic_ctl.word_sel = MAX_OFFSET_W'(ic_req.addr[OFFSET_WIDTH-1:0]);
            dc_ctl.enable   = dc_req.rd || dc_req.wr;
            dc_ctl.cmp      = 1'b1;
            dc_ctl.write    = dc_req.wr;
            dc_ctl.byte_en  = dc_req.byte_en;
            dc_ctl.word_sel = MAX_OFFSET_W'(dc_req.addr[OFFSET_WIDTH-1:0]);
        end
        IC_MISS, DOUBLE_MISS: begin
            ic_ctl.enable       = 1'b1;
            ic_ctl.word_sel     = MAX_OFFSET_W'(counter);
            ic_ctl.fill_word_en = fill_strobe;
        end
        DC_WRITEBACK: begin
            dc_ctl.enable   = 1'b1;             // Victim word onto the port
            dc_ctl.word_sel = MAX_OFFSET_W'(counter);
        end
        DC_MISS: begin
            dc_ctl.enable       = 1'b1;
            dc_ctl.word_sel     = MAX_OFFSET_W'(counter);
            dc_ctl.fill_word_en = fill_strobe;
        end
        default: ;
    endcase
end

// Command depends only on held state so it stays put while req is high
always_comb begin
    mem_cmd = '0;
    case (status)
        IC_MISS, DOUBLE_MISS: mem_cmd.addr = {ic_req.addr[ADDR_W-1:OFFSET_WIDTH], counter};
        DC_MISS:              mem_cmd.addr = {dc_req.addr[ADDR_W-1:OFFSET_WIDTH], counter};
        DC_WRITEBACK: begin
            mem_cmd.write = 1'b1;
            mem_cmd.addr  = {dc_victim_tag, dc_index, counter};
            mem_cmd.wdata = dc_victim_word;
        end
        default: ;
    endcase
end

////////////////////////////////////////
// Miss sequencing and four-phase master
////////////////////////////////////////
always_ff @(posedge clk) begin
    if (rst) begin
        status           <= NORMAL;
        counter          <= '0;
        phase            <= 1'b0;
        mem_req          <= 1'b0;
        write_after_load <= 1'b0;
    end else if (status == NORMAL) begin
        status           <= miss_next;
        write_after_load <= dc_req.wr && dc_miss;   // One more cycle to apply the write
    end else begin
        if (mem_req && mem_ack) begin
            mem_req <= 1'b0;
            phase   <= 1'b1;
        end else if (!mem_req && !phase && !mem_ack) begin
            mem_req <= 1'b1;
        end
        if (xfer_done) begin
            phase   <= 1'b0;
            counter <= counter + 1'b1;                // Wraps to 0 after the last word
            if (last_word) begin
                case (status)
                    DOUBLE_MISS:  status <= dc_wb_needed ? DC_WRITEBACK : DC_MISS;
                    DC_WRITEBACK: status <= DC_MISS;
                    default:      status <= NORMAL;
                endcase
            end
        end
    end
end

endmodule

// File: hw/cache_subsys.sv
`timescale 1ns/1ns

module cache_subsys import cache_pkg::*; #(
    parameter int INDEX_WIDTH  = 3,
    parameter int OFFSET_WIDTH = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  cpu_req_t          ic_req,
    input  cpu_req_t          dc_req,
    output logic [DATA_W-1:0] ic_rdata,
    output logic [DATA_W-1:0] dc_rdata,
    output logic              stall,
    output logic              mem_req,
    output mem_cmd_t          mem_cmd,
    input  logic              mem_ack,
    input  logic [DATA_W-1:0] mem_rdata
);

localparam int TAG_W = ADDR_W - INDEX_WIDTH - OFFSET_WIDTH;

cache_ctl_t              ic_ctl;
cache_ctl_t              dc_ctl;
logic                    ic_hit;
logic                    ic_valid;
logic                    dc_hit;
logic                    dc_valid;
logic                    dc_dirty;
logic [TAG_W-1:0]        ic_tag;
logic [TAG_W-1:0]        dc_tag;
logic [TAG_W-1:0]        dc_victim_tag;
logic [INDEX_WIDTH-1:0]  ic_index;
logic [INDEX_WIDTH-1:0]  dc_index;
logic [DATA_W-1:0]       fill_word;

// Address split {tag, index, offset}
assign ic_tag   = ic_req.addr[ADDR_W-1 -: TAG_W];
assign ic_index = ic_req.addr[OFFSET_WIDTH +: INDEX_WIDTH];
assign dc_tag   = dc_req.addr[ADDR_W-1 -: TAG_W];
assign dc_index = dc_req.addr[OFFSET_WIDTH +: INDEX_WIDTH];

cache_ctrl #(
    .INDEX_WIDTH  (INDEX_WIDTH),
    .OFFSET_WIDTH (OFFSET_WIDTH)
) i_cache_ctrl (
    .clk            (clk),
    .rst            (rst),
    .ic_req         (ic_req),
    .dc_req         (dc_req),
    .ic_hit         (ic_hit),
    .ic_valid       (ic_valid),
    .dc_hit         (dc_hit),
    .dc_dirty       (dc_dirty),
    .dc_valid       (dc_valid),
    .dc_victim_tag  (dc_victim_tag),
    .dc_victim_word (dc_rdata),        // Victim word during writeback
    .mem_ack        (mem_ack),
    .mem_rdata      (mem_rdata),
    .ic_ctl         (ic_ctl),
    .dc_ctl         (dc_ctl),
    .fill_word      (fill_word),
    .stall          (stall),
    .mem_req        (mem_req),
    .mem_cmd        (mem_cmd)
);

// Instruction cache, read only
cache_2ways #(
    .INDEX_WIDTH  (INDEX_WIDTH),
    .OFFSET_WIDTH (OFFSET_WIDTH)
) ic (
    .clk          (clk),
    .rst          (rst),
    .enable       (ic_ctl.enable),
    .cmp          (ic_ctl.cmp),
    .write        (ic_ctl.write),
    .byte_en      (ic_ctl.byte_en),
    .fill_word_en (ic_ctl.fill_word_en),
    .tag          (ic_tag),
    .index        (ic_index),
    .word_sel     (ic_ctl.word_sel[OFFSET_WIDTH-1:0]),
    .wdata        ('0),
    .fill_word    (fill_word),
    .hit          (ic_hit),
    .valid        (ic_valid),
    .dirty        (),
    .victim_tag   (),
    .rdata        (ic_rdata)
);

// Data cache, write-back and write-allocate
cache_2ways #(
    .INDEX_WIDTH  (INDEX_WIDTH),
    .OFFSET_WIDTH (OFFSET_WIDTH)
) dc (
    .clk          (clk),
    .rst          (rst),
    .enable       (dc_ctl.enable),
    .cmp          (dc_ctl.cmp),
    .write        (dc_ctl.write),
    .byte_en      (dc_ctl.byte_en),
    .fill_word_en (dc_ctl.fill_word_en),
    .tag          (dc_tag),
    .index        (dc_index),
    .word_sel     (dc_ctl.word_sel[OFFSET_WIDTH-1:0]),
    .wdata        (dc_req.wdata),
    .fill_word    (fill_word),
    .hit          (dc_hit),
    .valid        (dc_valid),
    .dirty        (dc_dirty),
    .victim_tag   (dc_victim_tag),
    .rdata        (dc_rdata)
);

endmodule

// File: verif/tb_clkgen.sv
`timescale 1ns/1ns

module tb_clkgen #(
    parameter int PERIOD = 40
) (
    output logic clk
);

// Free running, starts low
initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
end

endmodule

// File: verif/cache_subsys_props.sv
`timescale 1ns/1ns

module cache_subsys_props import cache_pkg::*; (
    input logic     clk,
    input logic     rst,
    input logic     mem_req,
    input logic     mem_ack,
    input mem_cmd_t mem_cmd,
    input logic     stall
);

int unsigned fail_count = 0;

////////////////////////////////////////
// Four-phase memory handshake
////////////////////////////////////////
req_held_until_ack: assert property (@(posedge clk) disable iff (rst)
    mem_req && !mem_ack |=> mem_req)
    else begin
        $error("mem_req dropped before mem_ack was seen");
        fail_count++;
    end

cmd_stable_during_req: assert property (@(posedge clk) disable iff (rst)
    mem_req && $past(mem_req) |-> $stable(mem_cmd))
    else begin
        $error("mem_cmd changed while mem_req was high");
        fail_count++;
    end

no_req_while_ack: assert property (@(posedge clk) disable iff (rst)
    !mem_req && mem_ack |=> !mem_req)
    else begin
        $error("mem_req rose while mem_ack was still high");
        fail_count++;
    end

// CPU must be held during any memory traffic
stall_during_req: assert property (@(posedge clk) disable iff (rst)
    mem_req |-> stall)
    else begin
        $error("mem_req high without stall");
        fail_count++;
    end

endmodule

// File: verif/cache_subsys_tb.sv
`timescale 1ns/1ns

module cache_subsys_tb import cache_pkg::*; ();

localparam int INDEX_WIDTH  = 2;
localparam int OFFSET_WIDTH = 2;
localparam int MEM_WORDS    = 1 << ADDR_W;
localparam int STALL_LIMIT  = 200;       // Cycles
localparam int SEED         = 28;
localparam logic [DATA_W-1:0] INIT_KEY = 32'h5A3C_96E1;

localparam logic [1:0] PORT_D  = 2'b01;
localparam logic [1:0] PORT_I  = 2'b10;
localparam logic [1:0] PORT_ID = 2'b11;
localparam logic       RD = 1'b0;
localparam logic       WR = 1'b1;
localparam logic       HIT  = 1'b1;      // Completes without stall
localparam logic       MISS = 1'b0;

typedef struct packed {
    logic [1:0]        port;             // Bit 0 D side, bit 1 I side
    logic              wr;
    logic [BE_W-1:0]   byte_en;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              exp_hit;
    logic [3:0]        exp_wb;           // Write transfers expected
} op_t;

logic              clk;
logic              rst;
cpu_req_t          ic_req;
cpu_req_t          dc_req;
logic [DATA_W-1:0] ic_rdata;
logic [DATA_W-1:0] dc_rdata;
logic              stall;
logic              mem_req;
mem_cmd_t          mem_cmd;
logic              mem_ack;
logic [DATA_W-1:0] mem_rdata;

logic [DATA_W-1:0] mem_model [MEM_WORDS];
logic [DATA_W-1:0] shadow    [MEM_WORDS];   // Expected CPU view
op_t               ops [$];
int unsigned       wb_count;
int unsigned       ack_delay;
int unsigned       seed_dummy;

tb_clkgen #(.PERIOD(40)) i_clkgen (.clk(clk));

cache_subsys #(
    .INDEX_WIDTH  (INDEX_WIDTH),
    .OFFSET_WIDTH (OFFSET_WIDTH)
) i_cache_subsys (
    .clk       (clk),
    .rst       (rst),
    .ic_req    (ic_req),
    .dc_req    (dc_req),
    .ic_rdata  (ic_rdata),
    .dc_rdata  (dc_rdata),
    .stall     (stall),
    .mem_req   (mem_req),
    .mem_cmd   (mem_cmd),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata)
);

bind cache_subsys cache_subsys_props i_props (
    .clk     (clk),
    .rst     (rst),
    .mem_req (mem_req),
    .mem_ack (mem_ack),
    .mem_cmd (mem_cmd),
    .stall   (stall)
);

task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1, "Simulation stopped at first error");
endtask

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
        fail_run("Result differs from the expected value");
    end
endtask

// Only enabled bytes take the new data
function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                  input logic [DATA_W-1:0] new_word,
                                                  input logic [BE_W-1:0] be);
    logic [DATA_W-1:0] result;
    result = old_word;
    for (int b = 0; b < BE_W; b++) begin
        if (be[b]) result[b*8 +: 8] = new_word[b*8 +: 8];
    end
    return result;
endfunction

function automatic op_t make_op(input logic [1:0] port, input logic wr,
                                input logic [BE_W-1:0] be, input logic [ADDR_W-1:0] addr,
                                input logic [DATA_W-1:0] wdata, input logic exp_hit,
                                input logic [3:0] exp_wb);
    op_t op;
    op.port    = port;
    op.wr      = wr;
    op.byte_en = be;
    op.addr    = addr;
    op.wdata   = wdata;
    op.exp_hit = exp_hit;
    op.exp_wb  = exp_wb;
    return op;
endfunction

////////////////////////////////////////
// Stimulus table
////////////////////////////////////////
task automatic load_table();
    ops.push_back(make_op(PORT_D,  RD, 4'h0, 16'h0010, 32'h0, MISS, 4'd0));  // Cold miss
    ops.push_back(make_op(PORT_D,  RD, 4'h0, 16'h0011, 32'h0, HIT,  4'd0));
    ops.push_back(make_op(PORT_D,  WR, 4'h5, 16'h0012, 32'hDEADBEEF, HIT, 4'd0));
    ops.push_back(make_op(PORT_D,  RD, 4'h0, 16'h0012, 32'h0, HIT,  4'd0));
    ops.push_back(make_op(PORT_D,  RD, 4'h0, 16'h0020, 32'h0, MISS, 4'd0));  // Second way
    ops.push_back(make_op(PORT_D,  RD, 4'h0, 16'h0030, 32'h0, MISS, 4'd4));  // Dirty evict
    ops.push_back(make_op(PORT_D,  RD, 4'h0, 16'h0012, 32'h0, MISS, 4'd0));
    ops.push_back(make_op(PORT_ID, RD, 4'h0, 16'h0104, 32'h0, MISS, 4'd0));  // Double miss
    ops.push_back(make_op(PORT_ID, RD, 4'h0, 16'h0105, 32'h0, HIT,  4'd0));
    ops.push_back(make_op(PORT_D,  WR, 4'h6, 16'h0048, 32'h12345678, MISS, 4'd0));
    ops.push_back(make_op(PORT_D,  RD, 4'h0, 16'h0048, 32'h0, HIT,  4'd0));
    ops.push_back(make_op(PORT_I,  RD, 4'h0, 16'h0200, 32'h0, MISS, 4'd0));
    ops.push_back(make_op(PORT_I,  RD, 4'h0, 16'h0203, 32'h0, HIT,  4'd0));
    ops.push_back(make_op(PORT_D,  WR, 4'h8, 16'h0088, 32'hCAFEF00D, MISS, 4'd0));
    ops.push_back(make_op(PORT_D,  RD, 4'h0, 16'h00C8, 32'h0, MISS, 4'd4));  // Evicts 0x0048
    ops.push_back(make_op(PORT_D,  RD, 4'h0, 16'h0088, 32'h0, HIT,  4'd0));
endtask

task automatic apply_op(input op_t op);
    int unsigned wb_before;
    int          cycles;
    wb_before = wb_count;
    @(posedge clk);
    #2;
    ic_req = '0;
    dc_req = '0;
    if (op.port[0]) begin
        dc_req.rd      = !op.wr;
        dc_req.wr      = op.wr;
        dc_req.byte_en = op.byte_en;
        dc_req.addr    = op.addr;
        dc_req.wdata   = op.wdata;
    end
    if (op.port[1]) begin
        ic_req.rd   = 1'b1;
        ic_req.addr = op.addr;
    end
    @(negedge clk);
    check_value("stall", 32'(stall), 32'(!op.exp_hit));
    cycles = 0;
    while (stall) begin
        cycles++;
        if (cycles > STALL_LIMIT) fail_run("Timeout while waiting for stall to fall");
        @(negedge clk);
    end
    if (op.wr) begin
        shadow[op.addr] = merge_bytes(shadow[op.addr], op.wdata, op.byte_en);
    end else begin
        if (op.port[0]) check_value("dc_rdata", dc_rdata, shadow[op.addr]);
        if (op.port[1]) check_value("ic_rdata", ic_rdata, shadow[op.addr]);
    end
    check_value("write transfers", wb_count - wb_before, 32'(op.exp_wb));
endtask

////////////////////////////////////////
// Memory model
////////////////////////////////////////
task automatic serve_transfer();
    if (mem_cmd.write) begin
        // Victim data has to be what the CPU last stored
        check_value("mem_cmd.wdata", mem_cmd.wdata, shadow[mem_cmd.addr]);
        mem_model[mem_cmd.addr] = mem_cmd.wdata;
        wb_count++;
    end else begin
        mem_rdata = mem_model[mem_cmd.addr];
    end
endtask

always begin
    @(posedge clk);
    #2;
    if (!rst && mem_req && !mem_ack) begin
        ack_delay = $urandom % 4;           // 0 to 3 cycles
        repeat (ack_delay) begin
            @(posedge clk);
            #2;
        end
        serve_transfer();
        mem_ack = 1'b1;
    end else if (!mem_req && mem_ack) begin
        ack_delay = $urandom % 4;           // Slow release of ack too
        repeat (ack_delay) begin
            @(posedge clk);
            #2;
        end
        mem_ack = 1'b0;
    end
end

initial begin
    seed_dummy = $urandom(SEED);
    rst        = 1'b1;
    ic_req     = '0;
    dc_req     = '0;
    mem_ack    = 1'b0;
    mem_rdata  = '0;
    wb_count   = 0;
    for (int a = 0; a < MEM_WORDS; a++) begin
        mem_model[a] = 32'(a) ^ INIT_KEY;
        shadow[a]    = 32'(a) ^ INIT_KEY;
    end
    load_table();
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;
    @(negedge clk);
    check_value("stall", 32'(stall), 32'd0);        // Idle after reset
    check_value("mem_req", 32'(mem_req), 32'd0);
    foreach (ops[i]) begin
        apply_op(ops[i]);
    end
    if (i_cache_subsys.i_props.fail_count == 0) begin
        $display("Finished with no errors");
        $finish;
    end else begin
        fail_run("A memory handshake or stall assertion failed");
    end
end

endmodule

// File: cache_subsys.f
hw/cache_pkg.sv
hw/cache_2ways.sv
hw/cache_ctrl.sv
hw/cache_subsys.sv
verif/tb_clkgen.sv
verif/cache_subsys_props.sv
verif/cache_subsys_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and decide from the simulation output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module cache_subsys_tb -f cache_subsys.f \
    || { echo "Build failed"; exit 1; }

sim_out="$(./obj_dir/Vcache_subsys_tb 2>&1)"
echo "$sim_out"
echo "$sim_out" | grep -qx "Finished with no errors" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
